// File: compile.f
+incdir+include
logic/corr_pkg.sv
logic/lane_sequencer.sv
logic/tap_sum_mem.sv
logic/stream_reg_slice.sv
logic/bit_correlator.sv
logic/corr_peak_detect.sv
logic/corr_top.sv
sim/tb_clkgen.sv
sim/tb_corr_checker.sv
sim/tb_corr_top.sv

// File: include/corr_code.svh
/*
 * Fixed bipolar correlation code and peak threshold of the correlator.
 */
`ifndef CORR_CODE_SVH
`define CORR_CODE_SVH

// one bit per tap, 1 adds the sample and 0 subtracts it
// tap 0 sees the oldest word, tap CORR_LEN-1 the newest
localparam logic [CORR_LEN-1:0] CORR_CODE = 8'b1011_0001;

// lane magnitude at or above this value counts as a hit
localparam int PEAK_THRESH = 20;

`endif

// File: logic/bit_correlator.sv
/*
 * Time-multiplexed bipolar correlator: one adder chain shared by all
 * lanes, per-lane partial sums kept between taps, registered output.
 */
module bit_correlator
  import corr_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            s_valid,
  output logic            s_ready,
  input  logic [IN_W-1:0] s_data,
  output logic            m_valid,
  input  logic            m_ready,
  output corr_word_t      m_data
);

  logic              enable;
  logic              step;
  logic              s_fire;
  logic [LANE_W-1:0] lane;
  logic [LANE_W-1:0] lane_next;
  logic              sweep_last;

  sample_t lane_sample;
  acc_t    sample_ext;
  acc_t    tap_in  [CORR_LEN];
  acc_t    tap_out [CORR_LEN];

  acc_t       out_mem [NUM_LANES];
  corr_word_t results;
  logic       results_valid;
  logic       slice_in_ready;

  //////////////////////////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////////////////////////

  // stall only when finished results cannot leave, slice still full
  assign enable  = ~(results_valid & ~slice_in_ready);
  assign step    = enable & s_valid;
  assign s_ready = enable & sweep_last;
  assign s_fire  = s_valid & s_ready;

  lane_sequencer u_lane_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (enable),
    .s_valid    (s_valid),
    .lane       (lane),
    .lane_next  (lane_next),
    .sweep_last (sweep_last)
  );

  // pick this cycle's lane out of the held word
  assign lane_sample = s_data[lane*SAMPLE_W +: SAMPLE_W];
  assign sample_ext  = acc_t'(lane_sample);

  //////////////////////////////////////////////////////////////////////
  // adder chain
  //////////////////////////////////////////////////////////////////////

  // first tap starts every lane from zero
  assign tap_in[0] = '0;

  genvar j;
  generate
    for (j = 1; j < CORR_LEN; j++) begin : g_tap_mem
      tap_sum_mem u_tap_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (step),
        .wr_lane (lane),
        .wr_sum  (tap_out[j-1]),
        .rd_lane (lane_next),
        .rd_sum  (tap_in[j])
      );
    end

    for (j = 0; j < CORR_LEN; j++) begin : g_tap_add
      // code bit set means weight +1
      assign tap_out[j] = CORR_CODE[j] ? tap_in[j] + sample_ext
                                       : tap_in[j] - sample_ext;
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // output collection
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        out_mem[i] <= '0;
      end
    end else if (step) begin
      out_mem[lane] <= tap_out[CORR_LEN-1];
    end
  end

  // widen each lane, lane 0 at the bottom
  genvar n;
  generate
    for (n = 0; n < NUM_LANES; n++) begin : g_pack
      assign results[n*OUT_W +: OUT_W] = OUT_W'(out_mem[n]);
    end
  endgenerate

  // all lanes are complete the cycle after the word is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      results_valid <= 1'b0;
    end else if (s_fire) begin
      results_valid <= 1'b1;
    end else if (slice_in_ready) begin
      results_valid <= 1'b0;
    end
  end

  stream_reg_slice #(
    .payload_t (corr_word_t)
  ) u_out_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (results_valid),
    .in_ready  (slice_in_ready),
    .in_data   (results),
    .out_valid (m_valid),
    .out_ready (m_ready),
    .out_data  (m_data)
  );

endmodule

// File: logic/corr_peak_detect.sv
/*
 * Peak detector: flags each lane whose correlation magnitude reaches
 * the threshold and registers the sums together with the hit mask.
 */
module corr_peak_detect
  import corr_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  c_valid,
  output logic                  c_ready,
  input  corr_word_t            c_data,
  output logic                  m_valid,
  input  logic                  m_ready,
  output logic [OUT_DATA_W-1:0] m_data,
  output logic [NUM_LANES-1:0]  m_hits
);

  logic [OUT_W-1:0]     lane_sum [NUM_LANES];
  logic [OUT_W-1:0]     lane_mag [NUM_LANES];
  logic [NUM_LANES-1:0] hits;

  peak_word_t det_word;
  peak_word_t out_word;

  //////////////////////////////////////////////////////////////////////
  // per-lane magnitude compare
  //////////////////////////////////////////////////////////////////////

  genvar n;
  generate
    for (n = 0; n < NUM_LANES; n++) begin : g_lane
      assign lane_sum[n] = c_data[n*OUT_W +: OUT_W];

      // negating the most negative value still reads right as unsigned
      assign lane_mag[n] = lane_sum[n][OUT_W-1] ? -lane_sum[n] : lane_sum[n];

      assign hits[n] = (lane_mag[n] >= OUT_W'(PEAK_THRESH));
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  // sums pass through untouched
  assign det_word.sums = c_data;
  assign det_word.hits = hits;

  stream_reg_slice #(
    .payload_t (peak_word_t)
  ) u_out_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (c_valid),
    .in_ready  (c_ready),
    .in_data   (det_word),
    .out_valid (m_valid),
    .out_ready (m_ready),
    .out_data  (out_word)
  );

  assign m_data = out_word.sums;
  assign m_hits = out_word.hits;

endmodule

// File: logic/corr_pkg.sv
/*
 * Correlator package with stream sizes, derived widths, payload types
 * and the fixed correlation code.
 */
package corr_pkg;

  //////////////////////////////////////////////////////////////////////
  // stream geometry
  //////////////////////////////////////////////////////////////////////

  // lane count must stay a power of two, the lane counter wraps freely
  localparam int NUM_LANES = 4;
  localparam int SAMPLE_W  = 4;
  localparam int IN_W      = NUM_LANES * SAMPLE_W;
  localparam int LANE_W    = $clog2(NUM_LANES);

  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(NUM_LANES - 1);

  //////////////////////////////////////////////////////////////////////
  // code length and arithmetic widths
  //////////////////////////////////////////////////////////////////////

  localparam int CORR_LEN = 8;

  // holds CORR_LEN full-scale samples of either sign
  localparam int ACC_W = 8;

  // each output lane is the sign-extended chain result
  localparam int OUT_W      = 10;
  localparam int OUT_DATA_W = NUM_LANES * OUT_W;

  `include "corr_code.svh"

  //////////////////////////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  // lane 0 sits in the least significant bits
  typedef logic [OUT_DATA_W-1:0] corr_word_t;

  typedef struct packed {
    logic [NUM_LANES-1:0] hits;
    corr_word_t           sums;
  } peak_word_t;

endpackage

// File: logic/corr_top.sv
/*
 * Correlator top level: bipolar correlator followed by peak detector.
 */
module corr_top
  import corr_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  logic [IN_W-1:0]       s_data,
  output logic                  m_valid,
  input  logic                  m_ready,
  output logic [OUT_DATA_W-1:0] m_data,
  output logic [NUM_LANES-1:0]  m_hits
);

  // correlator to peak detector
  logic       c_valid;
  logic       c_ready;
  corr_word_t c_data;

  bit_correlator u_corr (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (c_valid),
    .m_ready (c_ready),
    .m_data  (c_data)
  );

  corr_peak_detect u_peak (
    .clk     (clk),
    .rst_n   (rst_n),
    .c_valid (c_valid),
    .c_ready (c_ready),
    .c_data  (c_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_hits  (m_hits)
  );

endmodule

// File: logic/lane_sequencer.sv
/*
 * Lane sequencer: steps through the lanes of the held input word,
 * one lane per enabled cycle, and flags the last lane of the sweep.
 */
module lane_sequencer
  import corr_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  logic              s_valid,
  output logic [LANE_W-1:0] lane,
  output logic [LANE_W-1:0] lane_next,
  output logic              sweep_last
);

  logic step;

  // advance only while a word is offered and the chain may run
  assign step = enable & s_valid;

  // power-of-two lane count, so the increment wraps to zero by itself
  assign lane_next = lane + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane <= '0;
    end else if (step) begin
      lane <= lane_next;
    end
  end

  // last lane of the word, the input is freed here
  assign sweep_last = (lane == LAST_LANE);

endmodule

// File: logic/stream_reg_slice.sv
/*
 * One-entry valid/ready output register for an arbitrary payload type.
 */
module stream_reg_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic load;

  // free when empty or when the held word leaves this cycle
  assign in_ready = ~out_valid | out_ready;
  assign load     = in_valid & in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= in_data;
    end
  end

endmodule

// File: logic/tap_sum_mem.sv
/*
 * Per-lane partial sum store between two neighbouring taps.
 * Written at the current lane, read at the next lane one cycle later.
 */
module tap_sum_mem
  import corr_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  logic [LANE_W-1:0] wr_lane,
  input  acc_t              wr_sum,
  input  logic [LANE_W-1:0] rd_lane,
  output acc_t              rd_sum
);

  // one partial sum per lane
  acc_t mem [NUM_LANES];

  // reset clears the history so that the first words see zeros
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        mem[i] <= '0;
      end
      rd_sum <= '0;
    end else if (enable) begin
      mem[wr_lane] <= wr_sum;
      // next lane is never the one written, so this is the previous word
      rd_sum <= mem[rd_lane];
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the correlator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_corr_top -o sim_corr_top

sim_out=$(./obj_dir/sim_corr_top)
echo "$sim_out"

# the testbench prints the pass line only when every check held
if grep -qx "TB PASSED" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// File: sim/tb_clkgen.sv
/*
 * Testbench clock and reset: 100 ns clock, active-low reset for 3 cycles.
 */
module tb_clkgen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // release a little after the edge, away from the sampling point
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    rst_n = 1'b1;
  end

endmodule

// File: sim/tb_corr_checker.sv
/*
 * Correlator checker: reference model fed by accepted input words and
 * compared with every output word, plus input rate and reset checks.
 */
module tb_corr_checker
  import corr_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  s_valid,
  input  logic                  s_ready,
  input  logic [IN_W-1:0]       s_data,
  input  logic                  m_valid,
  input  logic                  m_ready,
  input  logic [OUT_DATA_W-1:0] m_data,
  input  logic [NUM_LANES-1:0]  m_hits,
  output int                    err_count,
  output int                    in_count,
  output int                    out_count
);
  timeunit 1ns;
  timeprecision 100ps;

  int   errs = 0;
  int   n_in = 0;
  int   n_out = 0;
  int   cycle = 0;
  int   last_in_cycle = 0;
  logic after_reset = 1'b0;

  // sample history per lane, index CORR_LEN-1 is the newest word
  int hist [NUM_LANES][CORR_LEN];

  logic [OUT_DATA_W-1:0] exp_sums_q [$];
  logic [NUM_LANES-1:0]  exp_hits_q [$];

  assign err_count = errs;
  assign in_count  = n_in;
  assign out_count = n_out;

  task automatic check_idle(input string when_txt);
    if (s_ready !== 1'b0 || m_valid !== 1'b0) begin
      errs++;
      $display("FAIL t=%0t: s_ready=%b m_valid=%b %s, both expected low",
               $time, s_ready, m_valid, when_txt);
    end
  endtask

  // shift the word into the history, then sum with the code signs
  task automatic add_expected(input logic [IN_W-1:0] word);
    logic [OUT_DATA_W-1:0] sums;
    logic [NUM_LANES-1:0]  hits;
    int                    acc;
    for (int n = 0; n < NUM_LANES; n++) begin
      for (int j = 0; j < CORR_LEN - 1; j++) begin
        hist[n][j] = hist[n][j+1];
      end
      hist[n][CORR_LEN-1] = int'($signed(word[n*SAMPLE_W +: SAMPLE_W]));
      acc = 0;
      for (int j = 0; j < CORR_LEN; j++) begin
        acc += CORR_CODE[j] ? hist[n][j] : -hist[n][j];
      end
      sums[n*OUT_W +: OUT_W] = OUT_W'(acc);
      hits[n] = ((acc < 0) ? -acc : acc) >= PEAK_THRESH;
    end
    exp_sums_q.push_back(sums);
    exp_hits_q.push_back(hits);
    n_in++;
  endtask

  task automatic compare_output();
    logic [OUT_DATA_W-1:0] sums;
    logic [NUM_LANES-1:0]  hits;
    if (exp_sums_q.size() == 0) begin
      errs++;
      $display("output word %0d at t=%0t has no matching input word", n_out, $time);
    end else begin
      sums = exp_sums_q.pop_front();
      hits = exp_hits_q.pop_front();
      for (int n = 0; n < NUM_LANES; n++) begin
        if (m_data[n*OUT_W +: OUT_W] !== sums[n*OUT_W +: OUT_W]) begin
          errs++;
          $display("FAIL t=%0t: word %0d lane %0d sum %0d, expected %0d", $time, n_out,
                   n, $signed(m_data[n*OUT_W +: OUT_W]), $signed(sums[n*OUT_W +: OUT_W]));
        end
      end
      if (m_hits !== hits) begin
        errs++;
        $display("FAIL t=%0t: word %0d hits %b, expected %b", $time, n_out, m_hits, hits);
      end
    end
    n_out++;
  endtask

  // sampled mid-cycle, inputs and outputs are both settled here
  always @(negedge clk) begin
    cycle++;
    if (!rst_n) begin
      for (int n = 0; n < NUM_LANES; n++) begin
        for (int j = 0; j < CORR_LEN; j++) begin
          hist[n][j] = 0;
        end
      end
      after_reset = 1'b1;
      check_idle("during reset");
    end else begin
      if (after_reset) begin
        check_idle("just after reset");
      end
      after_reset = 1'b0;
      if (m_valid && m_ready) begin
        compare_output();
      end
      if (s_valid && s_ready) begin
        if (n_in > 0 && cycle - last_in_cycle < NUM_LANES) begin
          errs++;
          $display("FAIL t=%0t: input words taken %0d cycles apart", $time,
                   cycle - last_in_cycle);
        end
        last_in_cycle = cycle;
        add_expected(s_data);
      end
    end
  end

endmodule

// File: sim/tb_corr_top.sv
/*
 * Correlator testbench: seeded random words, a full-scale code run,
 * random output back-pressure, drain with timeout and final report.
 */
module tb_corr_top
  import corr_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RANDOM_WORDS  = 200;
  localparam int BUSY_WORDS    = 100;
  localparam int DRIVE_DELAY   = 10;
  localparam int RESET_TIMEOUT = 20;
  localparam int SEND_TIMEOUT  = 2000;
  localparam int DRAIN_TIMEOUT = 4000;

  logic                  clk;
  logic                  rst_n;
  logic                  s_valid;
  logic                  s_ready;
  logic [IN_W-1:0]       s_data;
  logic                  m_valid;
  logic                  m_ready;
  logic [OUT_DATA_W-1:0] m_data;
  logic [NUM_LANES-1:0]  m_hits;

  int err_count;
  int in_count;
  int out_count;
  int other_errs = 0;
  // percent of cycles with m_ready high
  int ready_pct  = 70;
  bit stalled    = 1'b0;

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  corr_top u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_hits  (m_hits)
  );

  tb_corr_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_data    (s_data),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data),
    .m_hits    (m_hits),
    .err_count (err_count),
    .in_count  (in_count),
    .out_count (out_count)
  );

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  // hold the word until a transfer edge, then drop valid
  task automatic send_word(input logic [IN_W-1:0] word);
    logic accepted;
    int   waited;
    accepted = 1'b0;
    waited   = 0;
    s_valid  = 1'b1;
    s_data   = word;
    while (!accepted && waited < SEND_TIMEOUT) begin
      @(negedge clk);
      accepted = s_ready;
      next_cycle();
      waited++;
    end
    s_valid = 1'b0;
    s_data  = IN_W'($urandom());
    if (!accepted) begin
      other_errs++;
      stalled = 1'b1;
      $display("input word not taken within %0d cycles, t=%0t", SEND_TIMEOUT, $time);
    end
  endtask

  // mostly back-to-back, now and then a short pause
  task automatic idle_gap();
    int gap;
    gap = 0;
    if ($urandom_range(3) == 0) begin
      gap = $urandom_range(6, 1);
    end
    repeat (gap) next_cycle();
  endtask

  // lane 0 matches the code at full scale, lane 1 opposes it,
  // lane 2 lands just above the threshold and lane 3 below it
  function automatic logic [IN_W-1:0] code_word(input logic w);
    logic [IN_W-1:0] word;
    word = '0;
    word[0*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'(w ? 7 : -8);
    word[1*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'(w ? -8 : 7);
    word[2*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'(w ? 3 : -3);
    word[3*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'(w ? -2 : 2);
    return word;
  endfunction

  initial begin
    m_ready = 1'b0;
    forever begin
      next_cycle();
      m_ready = ($urandom_range(99) < ready_pct);
    end
  end

  initial begin
    int waited;
    void'($urandom(94535));
    s_valid = 1'b0;
    s_data  = '0;

    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      other_errs++;
      stalled = 1'b1;
      $display("reset was not released within %0d cycles", RESET_TIMEOUT);
    end
    repeat (2) next_cycle();

    for (int i = 0; i < RANDOM_WORDS && !stalled; i++) begin
      send_word(IN_W'($urandom()));
      idle_gap();
    end

    // code pattern twice over, hits of both signs
    for (int i = 0; i < 2 * CORR_LEN && !stalled; i++) begin
      send_word(code_word(CORR_CODE[i % CORR_LEN]));
    end

    // back-to-back words against heavy back-pressure
    ready_pct = 25;
    for (int i = 0; i < BUSY_WORDS && !stalled; i++) begin
      send_word(IN_W'($urandom()));
    end

    ready_pct = 100;
    waited = 0;
    while (out_count != in_count && waited < DRAIN_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    // a few idle cycles catch any duplicated word
    repeat (10) next_cycle();
    if (out_count != in_count) begin
      other_errs++;
      $display("%0d input words accepted but %0d output words seen", in_count, out_count);
    end

    $display("words in=%0d out=%0d, value errors=%0d, other errors=%0d",
             in_count, out_count, err_count, other_errs);
    if (err_count == 0 && other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
